// ==== dv/pwr_ctrl_cases.txt ====
# op addr data exp resp, all hex
# write: data, exp=strobes | read/wait: data=mask, exp=value | stall: exp=cycles | mute: data=flag
read 00 ffffffff 00000000 0
read 04 ffffffff 00000000 0
write 00 00000004 f 0
read 00 ffffffff 00000004 0
wait 04 00000030 00000010 0
read 04 ffffffff 00000010 0
write 00 00000000 f 0
wait 04 00000030 00000000 0
read 04 ffffffff 00000000 0
write 00 00000030 f 0
wait 04 00000300 00000200 0
read 04 ffffffff 00000200 0
write 00 00000000 f 0
wait 04 00000300 00000000 0
mute 00 1 0 0
write 00 00000001 f 0
wait 04 00000004 00000004 0
read 04 00000007 00000007 0
mute 00 0 0 0
wait 04 00000003 00000001 0
read 04 ffffffff 00000005 0
write 08 00000001 f 0
read 04 ffffffff 00000001 0
write 00 00000000 f 0
wait 04 00000003 00000000 0
write 00 00000015 2 0
read 00 ffffffff 00000000 0
write 04 ffffffff f 0
read 00 ffffffff 00000000 0
write 10 00000001 f 2
read 10 ffffffff 00000000 2
stall 00 00000000 8 0
read 00 ffffffff 00000000 0

// ==== pwr_ctrl.f ====
design/pwr_ctrl_pkg.sv
design/pwr_settle_timer.sv
design/pwr_domain_fsm.sv
design/pwr_ctrl_regs.sv
design/pwr_ctrl_top.sv
dv/pwr_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the power control testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module pwr_ctrl_tb -f pwr_ctrl.f -o pwr_ctrl_sim \
  || exit 1
./obj_dir/pwr_ctrl_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
  && exit 0 || exit 1

// ==== dv/pwr_ctrl_tb.sv ====
// ========================================
// power control testbench with AXI4-Lite
// driver, switch ack model and case runner
// ========================================
`timescale 1ns/1ps

module pwr_ctrl_tb;

  import pwr_ctrl_pkg::*;

  localparam int NUM_DOMAINS = 3;
  localparam int STEP_CYCLES = 4;
  localparam int ACK_TIMEOUT = 64;
  localparam int WAIT_LIMIT = 200;
  localparam int POLL_LIMIT = 300;
  localparam int DRIVE_DLY = 1;
  localparam int SEED = 24370;

  logic                            clk_i;
  logic                            arst_n_i;
  axil_req_t                       req;
  axil_rsp_t                       rsp;
  logic          [NUM_DOMAINS-1:0] ack_n;
  pwr_ctrl_out_t [NUM_DOMAINS-1:0] pwr_ctrl;
  pwr_ctrl_out_t [NUM_DOMAINS-1:0] ctrl_prev;
  logic          [NUM_DOMAINS-1:0] mute;

  int ack_delay [NUM_DOMAINS];
  int ack_cnt [NUM_DOMAINS];
  int last_edge [NUM_DOMAINS];
  int cyc;
  int r_old;
  int r_new;
  int err_cnt;
  int mon_err_cnt;
  bit timed_out;

  pwr_ctrl_top #(
    .NUM_DOMAINS(NUM_DOMAINS),
    .STEP_CYCLES(STEP_CYCLES),
    .ACK_TIMEOUT(ACK_TIMEOUT)
  ) dut0 (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .axil_req_i    (req),
    .axil_rsp_o    (rsp),
    .pwrgate_ack_ni(ack_n),
    .pwr_ctrl_o    (pwr_ctrl)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // switch ack follows its enable after a per-domain delay
  initial begin
    ack_n = '1;
    ack_cnt = '{default: 0};
    void'($urandom(SEED));
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      ack_delay[d] = 1 + int'($urandom % 10);
    end
    forever begin
      @(posedge clk_i);
      #DRIVE_DLY;
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        if (mute[d] || pwr_ctrl[d].pwrgate_en_n == ack_n[d]) begin
          ack_cnt[d] = 0;
        end else if (ack_cnt[d] + 1 >= ack_delay[d]) begin
          ack_n[d] = pwr_ctrl[d].pwrgate_en_n;
          ack_cnt[d] = 0;
        end else begin
          ack_cnt[d] = ack_cnt[d] + 1;
        end
      end
    end
  end

  // position of a control word along the down sequence
  // bits are pwrgate, isogate, rst, clkgate, retentive
  function automatic int ctrl_rank(input logic [4:0] v);
    case (v)
      5'b11111: return 0;
      5'b11101: return 1;
      5'b10101: return 2;
      5'b10001: return 3;
      5'b00001, 5'b10000: return 4;
      default: return -1;
    endcase
  endfunction

  // edge order monitor allowing one sequence step per edge
  initial begin
    cyc = 0;
    mon_err_cnt = 0;
    ctrl_prev = '1;
    last_edge = '{default: 0};
    forever begin
      @(negedge clk_i);
      cyc++;
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        if (arst_n_i && pwr_ctrl[d] != ctrl_prev[d]) begin
          r_old = ctrl_rank(ctrl_prev[d]);
          r_new = ctrl_rank(pwr_ctrl[d]);
          if (r_new < 0 || (r_new - r_old != 1 && r_old - r_new != 1)) begin
            $display("domain %0d controls stepped out of order from %b to %b at %0t",
                     d, ctrl_prev[d], pwr_ctrl[d], $time);
            mon_err_cnt++;
          end else if (r_old != 0 && r_old != 4 && cyc - last_edge[d] < STEP_CYCLES) begin
            $display("domain %0d control edge came %0d cycles after the previous one at %0t",
                     d, cyc - last_edge[d], $time);
            mon_err_cnt++;
          end else if (r_old == 3 && r_new == 2 && !ack_n[d]) begin
            $display("domain %0d reset released before the switch ack at %0t", d, $time);
            mon_err_cnt++;
          end
          last_edge[d] = cyc;
        end
        ctrl_prev[d] = pwr_ctrl[d];
      end
    end
  end

  task automatic timeout_hit(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    timed_out = 1'b1;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
    if (exp_v !== got_v) begin
      $display("Error: %0t %s expected %h got %h", $time, name, exp_v, got_v);
      err_cnt++;
    end
  endtask

  // hold > 0 keeps bready low and presents the write a second time
  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold,
                           output logic [1:0] resp);
    int n;
    resp = 2'b11;
    @(posedge clk_i);
    #DRIVE_DLY;
    req.awvalid = 1'b1;
    req.awaddr = addr;
    req.wvalid = 1'b1;
    req.wdata = data;
    req.wstrb = strb;
    req.bready = (hold == 0);
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!rsp.awready && n < WAIT_LIMIT);
    if (!rsp.awready) begin
      timeout_hit("awready");
      return;
    end
    check_value("wready", 32'h1, {31'b0, rsp.wready});
    if (hold > 0) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      for (int i = 0; i < hold; i++) begin
        @(negedge clk_i);
        if (rsp.awready || rsp.wready) begin
          $display("write accepted at %0t while the previous response was held", $time);
          err_cnt++;
        end
      end
      @(posedge clk_i);
      #DRIVE_DLY;
      req.bready = 1'b1;
      n = 0;
      do begin
        @(negedge clk_i);
        n++;
      end while (!rsp.awready && n < WAIT_LIMIT);
      if (!rsp.awready) begin
        timeout_hit("awready after bready");
        return;
      end
      check_value("wready", 32'h1, {31'b0, rsp.wready});
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    req.awvalid = 1'b0;
    req.wvalid = 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!rsp.bvalid && n < WAIT_LIMIT);
    if (!rsp.bvalid) begin
      timeout_hit("bvalid");
      return;
    end
    resp = rsp.bresp;
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    data = '0;
    resp = 2'b11;
    @(posedge clk_i);
    #DRIVE_DLY;
    req.arvalid = 1'b1;
    req.araddr = addr;
    req.rready = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!rsp.arready && n < WAIT_LIMIT);
    if (!rsp.arready) begin
      timeout_hit("arready");
      return;
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    req.arvalid = 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!rsp.rvalid && n < WAIT_LIMIT);
    if (!rsp.rvalid) begin
      timeout_hit("rvalid");
      return;
    end
    data = rsp.rdata;
    resp = rsp.rresp;
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  initial begin
    string       line;
    string       op;
    int          fd;
    int          cnt;
    int          polls;
    int          case_no;
    int          pass_cnt;
    int          fail_cnt;
    int          errs_before;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    logic [31:0] resp_exp;
    logic [31:0] rdata;
    logic [1:0]  resp;
    arst_n_i = 1'b0;
    req = '0;
    mute = '0;
    err_cnt = 0;
    timed_out = 1'b0;
    pass_cnt = 0;
    fail_cnt = 0;
    case_no = 0;
    repeat (8) @(posedge clk_i);
    #DRIVE_DLY;
    arst_n_i = 1'b1;

    // every control inactive out of reset
    errs_before = err_cnt + mon_err_cnt;
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      check_value($sformatf("pwr_ctrl_o[%0d]", d), 32'h1f, {27'b0, pwr_ctrl[d]});
    end
    if (err_cnt + mon_err_cnt == errs_before) begin
      pass_cnt++;
      $display("case 0 reset controls: ok");
    end else begin
      fail_cnt++;
      $display("case 0 reset controls: failed");
    end

    fd = $fopen("dv/pwr_ctrl_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      err_cnt++;
    end
    while (fd != 0 && !timed_out && !$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) continue;
      if (line.len() < 4 || line[0] == "#") continue;
      cnt = $sscanf(line, "%s %h %h %h %h", op, addr, data, expv, resp_exp);
      if (cnt != 5) begin
        $display("malformed case line: %s", line);
        err_cnt++;
        continue;
      end
      case_no++;
      errs_before = err_cnt + mon_err_cnt;
      if (op == "write" || op == "stall") begin
        if (op == "write") begin
          bus_write(addr[7:0], data, expv[3:0], 0, resp);
        end else begin
          bus_write(addr[7:0], data, 4'hf, int'(expv), resp);
        end
        if (!timed_out) check_value("bresp", resp_exp, {30'b0, resp});
      end else if (op == "read") begin
        bus_read(addr[7:0], rdata, resp);
        if (!timed_out) begin
          check_value("rdata", expv, rdata & data);
          check_value("rresp", resp_exp, {30'b0, resp});
        end
      end else if (op == "wait") begin
        polls = 0;
        do begin
          bus_read(addr[7:0], rdata, resp);
          polls++;
        end while (!timed_out && (rdata & data) != expv && polls < POLL_LIMIT);
        if (!timed_out && (rdata & data) != expv) timeout_hit("register value");
      end else if (op == "mute") begin
        mute[addr] = data[0];
      end else begin
        $display("unknown operation %s", op);
        err_cnt++;
      end
      if (err_cnt + mon_err_cnt == errs_before && !timed_out) begin
        pass_cnt++;
        $display("case %0d %s %h: ok", case_no, op, addr[7:0]);
      end else begin
        fail_cnt++;
        $display("case %0d %s %h: failed", case_no, op, addr[7:0]);
      end
    end
    if (fd != 0) $fclose(fd);

    $display("cases passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt + mon_err_cnt == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== design/pwr_ctrl_top.sv ====
// ======================================
// power control top, register block and
// one sequencer per domain
// ======================================
`timescale 1ns/1ps

module pwr_ctrl_top #(
  parameter int NUM_DOMAINS = 3,
  parameter int STEP_CYCLES = 4,
  parameter int ACK_TIMEOUT = 64
) (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  pwr_ctrl_pkg::axil_req_t                       axil_req_i,
  output pwr_ctrl_pkg::axil_rsp_t                       axil_rsp_o,
  input  logic                        [NUM_DOMAINS-1:0] pwrgate_ack_ni,
  output pwr_ctrl_pkg::pwr_ctrl_out_t [NUM_DOMAINS-1:0] pwr_ctrl_o
);

  import pwr_ctrl_pkg::*;

  pwr_cmd_t    [NUM_DOMAINS-1:0] domain_cmd;
  pwr_status_t [NUM_DOMAINS-1:0] domain_status;

  pwr_ctrl_regs #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) pwr_ctrl_regs_i (
    .clk_i,
    .arst_n_i,
    .axil_req_i,
    .axil_rsp_o,
    .status_i(domain_status),
    .cmd_o   (domain_cmd)
  );

  // domain 0 cpu, 1 peripheral, then memory banks
  for (genvar i = 0; i < NUM_DOMAINS; i++) begin : g_domain
    pwr_domain_fsm #(
      .STEP_CYCLES(STEP_CYCLES),
      .ACK_TIMEOUT(ACK_TIMEOUT)
    ) pwr_domain_fsm_i (
      .clk_i,
      .arst_n_i,
      .cmd_i         (domain_cmd[i]),
      .pwrgate_ack_ni(pwrgate_ack_ni[i]),
      .ctrl_o        (pwr_ctrl_o[i]),
      .status_o      (domain_status[i])
    );
  end

endmodule

// ==== design/pwr_ctrl_regs.sv ====
// ======================================
// AXI4-Lite slave with control, status
// and sticky error registers
// ======================================
`timescale 1ns/1ps

module pwr_ctrl_regs #(
  parameter int NUM_DOMAINS = 3
) (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  pwr_ctrl_pkg::axil_req_t                     axil_req_i,
  output pwr_ctrl_pkg::axil_rsp_t                     axil_rsp_o,
  input  pwr_ctrl_pkg::pwr_status_t [NUM_DOMAINS-1:0] status_i,
  output pwr_ctrl_pkg::pwr_cmd_t    [NUM_DOMAINS-1:0] cmd_o
);

  import pwr_ctrl_pkg::*;

  localparam int CTRL_W = 2 * NUM_DOMAINS;

  logic [CTRL_W-1:0]      ctrl_q;
  logic [NUM_DOMAINS-1:0] err_q, err_d;
  logic [DATA_W-1:0]      status_word;
  logic                   wr_hs, rd_hs;
  logic                   wr_ctrl, wr_clr, wr_hit;
  logic                   bvalid_q, rvalid_q;
  logic [1:0]             bresp_q, rresp_q, rd_resp;
  logic [DATA_W-1:0]      rdata_q, rd_data;

  // address and data accepted together, one write at a time
  assign wr_hs = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
  assign rd_hs = axil_req_i.arvalid && !rvalid_q;

  assign wr_ctrl = wr_hs && (axil_req_i.awaddr == CTRL_ADDR);
  assign wr_clr = wr_hs && (axil_req_i.awaddr == ERR_CLR_ADDR);
  assign wr_hit = axil_req_i.awaddr inside {CTRL_ADDR, STATUS_ADDR, ERR_CLR_ADDR};

  // 4 bits per domain, upper slots read zero
  for (genvar i = 0; i < MAX_DOMAINS; i++) begin : g_status
    if (i < NUM_DOMAINS) begin : g_used
      assign status_word[4*i +: 4] = {1'b0, err_q[i], status_i[i].state};
    end else begin : g_unused
      assign status_word[4*i +: 4] = 4'b0;
    end
  end

  for (genvar i = 0; i < NUM_DOMAINS; i++) begin : g_cmd
    assign cmd_o[i].off_req = ctrl_q[2*i];
    assign cmd_o[i].retain = ctrl_q[2*i+1];
  end

  // timeout pulse wins over a clear in the same cycle
  always_comb begin
    err_d = err_q;
    if (wr_clr) begin
      err_d = err_d & ~axil_req_i.wdata[NUM_DOMAINS-1:0];
    end
    for (int i = 0; i < NUM_DOMAINS; i++) begin
      if (status_i[i].ack_timeout) begin
        err_d[i] = 1'b1;
      end
    end
  end

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (axil_req_i.araddr)
      CTRL_ADDR:    rd_data = DATA_W'(ctrl_q);
      STATUS_ADDR:  rd_data = status_word;
      ERR_CLR_ADDR: rd_data = '0;
      default:      rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q <= '0;
      err_q <= '0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      err_q <= err_d;
      if (wr_ctrl) begin
        for (int b = 0; b < CTRL_W; b++) begin
          if (axil_req_i.wstrb[b/8]) begin
            ctrl_q[b] <= axil_req_i.wdata[b];
          end
        end
      end
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_hs) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  assign axil_rsp_o.awready = wr_hs;
  assign axil_rsp_o.wready = wr_hs;
  assign axil_rsp_o.bvalid = bvalid_q;
  assign axil_rsp_o.bresp = bresp_q;
  assign axil_rsp_o.arready = rd_hs;
  assign axil_rsp_o.rvalid = rvalid_q;
  assign axil_rsp_o.rdata = rdata_q;
  assign axil_rsp_o.rresp = rresp_q;

endmodule

// ==== design/pwr_domain_fsm.sv ====
// ======================================
// per-domain power-down, power-up and
// retention sequencer
// ======================================
`timescale 1ns/1ps

module pwr_domain_fsm #(
  parameter int STEP_CYCLES = 4,
  parameter int ACK_TIMEOUT = 64
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  pwr_ctrl_pkg::pwr_cmd_t      cmd_i,
  input  logic                        pwrgate_ack_ni,
  output pwr_ctrl_pkg::pwr_ctrl_out_t ctrl_o,
  output pwr_ctrl_pkg::pwr_status_t   status_o
);

  import pwr_ctrl_pkg::*;

  localparam logic [TIMER_W-1:0] STEP_VAL = TIMER_W'(STEP_CYCLES);
  localparam logic [TIMER_W-1:0] ACK_VAL = TIMER_W'(ACK_TIMEOUT);

  typedef enum logic [3:0] {
    ST_ON, ST_DN_CLK, ST_DN_ISO, ST_DN_RST, ST_DN_SW, ST_DN_RET,
    ST_OFF, ST_RETAIN, ST_UP_SW, ST_UP_RST, ST_UP_ISO, ST_UP_CLK
  } fsm_e;

  fsm_e               fsm_q, fsm_d;
  pwr_ctrl_out_t      ctrl_q, ctrl_d;
  logic               retain_q;
  logic               ack_to_q, ack_to_d;
  logic               load;
  logic [TIMER_W-1:0] load_val;
  logic               expired;

  pwr_settle_timer #(
    .TIMER_W(TIMER_W)
  ) settle_timer_i (
    .clk_i,
    .arst_n_i,
    .load_i    (load),
    .load_val_i(load_val),
    .expired_o (expired)
  );

  always_comb begin
    fsm_d = fsm_q;
    ctrl_d = ctrl_q;
    load = 1'b0;
    load_val = STEP_VAL;
    ack_to_d = 1'b0;
    case (fsm_q)
      ST_ON: begin
        if (cmd_i.off_req) begin
          ctrl_d.clkgate_en_n = 1'b0;
          load = 1'b1;
          fsm_d = ST_DN_CLK;
        end
      end
      ST_DN_CLK: begin
        if (expired) begin
          ctrl_d.isogate_en_n = 1'b0;
          load = 1'b1;
          fsm_d = ST_DN_ISO;
        end
      end
      ST_DN_ISO: begin
        if (expired) begin
          ctrl_d.rst_n = 1'b0;
          load = 1'b1;
          fsm_d = ST_DN_RST;
        end
      end
      ST_DN_RST: begin
        if (expired && retain_q) begin
          ctrl_d.retentive_en_n = 1'b0;
          load = 1'b1;
          fsm_d = ST_DN_RET;
        end else if (expired) begin
          ctrl_d.pwrgate_en_n = 1'b0;
          load = 1'b1;
          load_val = ACK_VAL;
          fsm_d = ST_DN_SW;
        end
      end
      ST_DN_RET: begin
        if (expired) begin
          fsm_d = ST_RETAIN;
        end
      end
      ST_DN_SW: begin
        if (!pwrgate_ack_ni) begin
          fsm_d = ST_OFF;
        end else if (expired) begin
          // flag the late switch and keep waiting
          ack_to_d = 1'b1;
          load = 1'b1;
          load_val = ACK_VAL;
        end
      end
      ST_OFF: begin
        if (!cmd_i.off_req) begin
          ctrl_d.pwrgate_en_n = 1'b1;
          load = 1'b1;
          load_val = ACK_VAL;
          fsm_d = ST_UP_SW;
        end
      end
      ST_RETAIN: begin
        if (!cmd_i.off_req) begin
          ctrl_d.retentive_en_n = 1'b1;
          load = 1'b1;
          fsm_d = ST_UP_RST;
        end
      end
      ST_UP_SW: begin
        if (pwrgate_ack_ni) begin
          load = 1'b1;
          fsm_d = ST_UP_RST;
        end else if (expired) begin
          ack_to_d = 1'b1;
          load = 1'b1;
          load_val = ACK_VAL;
        end
      end
      ST_UP_RST: begin
        if (expired) begin
          ctrl_d.rst_n = 1'b1;
          load = 1'b1;
          fsm_d = ST_UP_ISO;
        end
      end
      ST_UP_ISO: begin
        if (expired) begin
          ctrl_d.isogate_en_n = 1'b1;
          load = 1'b1;
          fsm_d = ST_UP_CLK;
        end
      end
      ST_UP_CLK: begin
        if (expired) begin
          ctrl_d.clkgate_en_n = 1'b1;
          fsm_d = ST_ON;
        end
      end
      default: fsm_d = ST_ON;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fsm_q <= ST_ON;
      ctrl_q <= '1;
      ack_to_q <= 1'b0;
    end else begin
      fsm_q <= fsm_d;
      ctrl_q <= ctrl_d;
      ack_to_q <= ack_to_d;
    end
  end

  // retention choice captured when leaving on
  always_ff @(posedge clk_i) begin
    if (fsm_q == ST_ON && cmd_i.off_req) begin
      retain_q <= cmd_i.retain;
    end
  end

  assign ctrl_o = ctrl_q;
  assign status_o.ack_timeout = ack_to_q;
  assign status_o.state = (fsm_q == ST_ON)     ? PWR_ON :
                          (fsm_q == ST_OFF)    ? PWR_OFF :
                          (fsm_q == ST_RETAIN) ? PWR_RETAIN : PWR_BUSY;

endmodule

// ==== design/pwr_settle_timer.sv ====
// ======================================
// loadable down-counter for step delays
// ======================================
`timescale 1ns/1ps

module pwr_settle_timer #(
  parameter int TIMER_W = pwr_ctrl_pkg::TIMER_W
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               load_i,
  input  logic [TIMER_W-1:0] load_val_i,
  output logic               expired_o
);

  logic [TIMER_W-1:0] count_q;
  logic               armed_q;

  // holds at zero once the count runs out
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
      armed_q <= 1'b0;
    end else if (load_i) begin
      count_q <= load_val_i;
      armed_q <= 1'b1;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // stays low after reset until a load has counted out
  assign expired_o = armed_q && (count_q == '0);

endmodule

// ==== design/pwr_ctrl_pkg.sv ====
// ======================================
// register map, power state codes and
// packed bundles for bus and domain signals
// ======================================
package pwr_ctrl_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int MAX_DOMAINS = 8;
  localparam int TIMER_W = 16;

  localparam logic [ADDR_W-1:0] CTRL_ADDR = 8'h00;
  localparam logic [ADDR_W-1:0] STATUS_ADDR = 8'h04;
  localparam logic [ADDR_W-1:0] ERR_CLR_ADDR = 8'h08;

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    PWR_ON     = 2'd0,
    PWR_OFF    = 2'd1,
    PWR_RETAIN = 2'd2,
    PWR_BUSY   = 2'd3
  } pwr_state_e;

  // all active low, high means inactive
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_out_t;

  typedef struct packed {
    logic off_req;
    logic retain;
  } pwr_cmd_t;

  typedef struct packed {
    pwr_state_e state;
    logic       ack_timeout;
  } pwr_status_t;

  typedef struct packed {
    logic                awvalid;
    logic [ADDR_W-1:0]   awaddr;
    logic                wvalid;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                bready;
    logic                arvalid;
    logic [ADDR_W-1:0]   araddr;
    logic                rready;
  } axil_req_t;

  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

endpackage
